// File: flist.f
hw/light_pkg.sv
hw/line_decoder.sv
hw/instruction_buffer.sv
hw/light_grid.sv
hw/light_puzzle_top.sv
verif/light_puzzle_sva.sv
verif/tb_light_puzzle.sv

// File: hw/instruction_buffer.sv
`timescale 1ns/1ns

module instruction_buffer import light_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   conf_clk,
    input  logic                   rst_n,
    input  logic                   wr_valid,
    input  op_e                    wr_op,
    input  logic [COORD_WIDTH-1:0] wr_x0,
    input  logic [COORD_WIDTH-1:0] wr_y0,
    input  logic [COORD_WIDTH-1:0] wr_x1,
    input  logic [COORD_WIDTH-1:0] wr_y1,
    input  logic                   wr_last,
    input  logic                   rd_pop,
    output logic                   rd_valid,
    output op_e                    rd_op,
    output logic [COORD_WIDTH-1:0] rd_x0,
    output logic [COORD_WIDTH-1:0] rd_y0,
    output logic [COORD_WIDTH-1:0] rd_x1,
    output logic [COORD_WIDTH-1:0] rd_y1,
    output logic                   rd_last,
    output logic                   overflow
);

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    logic [INSTR_WIDTH-1:0] mem [FIFO_DEPTH];
    logic [INSTR_WIDTH-1:0] head_word;
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [PTR_WIDTH:0]     count;
    logic [1:0]             head_op;
    logic                   full;
    logic                   do_write;
    logic                   do_read;

    assign full     = count == (PTR_WIDTH + 1)'(FIFO_DEPTH);
    assign do_write = wr_valid && !full;
    assign do_read  = rd_pop && rd_valid;
    assign rd_valid = count != '0;

    // EOT marker is just another word, so it stays behind its lines
    always_ff @(posedge conf_clk) begin
        if (do_write) begin
            mem[wr_ptr] <= {wr_last, wr_op, wr_x0, wr_y0, wr_x1, wr_y1};
        end
    end

    always_ff @(posedge conf_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + PTR_WIDTH'(1);
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + PTR_WIDTH'(1);
            end
            if (do_write && !do_read) begin
                count <= count + (PTR_WIDTH + 1)'(1);
            end else if (!do_write && do_read) begin
                count <= count - (PTR_WIDTH + 1)'(1);
            end
            // Word lost on a full buffer
            if (wr_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    assign head_word = mem[rd_ptr];
    assign {rd_last, head_op, rd_x0, rd_y0, rd_x1, rd_y1} = head_word;
    assign rd_op = op_e'(head_op);

endmodule

// File: hw/light_grid.sv
`timescale 1ns/1ns

module light_grid import light_pkg::*; #(
    parameter int GRID_SIZE = 16
) (
    input  logic                    conf_clk,
    input  logic                    rst_n,
    input  logic                    rd_valid,
    input  op_e                     rd_op,
    input  logic [COORD_WIDTH-1:0]  rd_x0,
    input  logic [COORD_WIDTH-1:0]  rd_y0,
    input  logic [COORD_WIDTH-1:0]  rd_x1,
    input  logic [COORD_WIDTH-1:0]  rd_y1,
    input  logic                    rd_last,
    output logic                    rd_pop,
    output logic                    result_valid,
    output logic [RESULT_WIDTH-1:0] result_count
);

    localparam int ROW_WIDTH = $clog2(GRID_SIZE);

    typedef enum logic [1:0] {
        G_IDLE,
        G_APPLY,
        G_COUNT
    } state_e;

    state_e                  state;
    logic [ROW_WIDTH-1:0]    row;
    logic [GRID_SIZE-1:0]    grid [GRID_SIZE];
    logic [GRID_SIZE-1:0]    col_mask;
    logic [GRID_SIZE-1:0]    mask_q;
    logic [GRID_SIZE-1:0]    cur_row;
    logic [GRID_SIZE-1:0]    row_next;
    op_e                     op_q;
    logic [COORD_WIDTH-1:0]  y0_q;
    logic [COORD_WIDTH-1:0]  y1_q;
    logic                    row_last;
    logic                    row_in_y;
    logic [RESULT_WIDTH-1:0] row_ones;
    logic [RESULT_WIDTH-1:0] acc;

    // Head is taken only between instructions
    assign rd_pop   = (state == G_IDLE) && rd_valid;
    assign cur_row  = grid[row];
    assign row_last = row == ROW_WIDTH'(GRID_SIZE - 1);
    assign row_in_y = (COORD_WIDTH'(row) >= y0_q) && (COORD_WIDTH'(row) <= y1_q);

    // Columns past the grid edge simply have no bit, which clips x
    always_comb begin
        for (int c = 0; c < GRID_SIZE; c++) begin
            col_mask[c] = (COORD_WIDTH'(c) >= rd_x0) && (COORD_WIDTH'(c) <= rd_x1);
        end
    end

    always_comb begin
        row_ones = '0;
        for (int c = 0; c < GRID_SIZE; c++) begin
            row_ones = row_ones + RESULT_WIDTH'(cur_row[c]);
        end
    end

    always_comb begin
        case (op_q)
            OP_ON:   row_next = cur_row | mask_q;
            OP_OFF:  row_next = cur_row & ~mask_q;
            default: row_next = cur_row ^ mask_q;
        endcase
    end

    always_ff @(posedge conf_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= G_IDLE;
            row          <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            case (state)
                G_IDLE: begin
                    if (rd_pop) begin
                        row   <= '0;
                        state <= rd_last ? G_COUNT : G_APPLY;
                    end
                end
                G_APPLY: begin
                    row <= row + ROW_WIDTH'(1);
                    if (row_last) begin
                        state <= G_IDLE;
                    end
                end
                G_COUNT: begin
                    row <= row + ROW_WIDTH'(1);
                    // Total shows up the cycle after the last row
                    if (row_last) begin
                        state        <= G_IDLE;
                        result_valid <= 1'b1;
                    end
                end
                default: state <= G_IDLE;
            endcase
        end
    end

    // Rows are updated in place, and counting leaves them dark
    always_ff @(posedge conf_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < GRID_SIZE; r++) begin
                grid[r] <= '0;
            end
        end else if ((state == G_APPLY) && row_in_y) begin
            grid[row] <= row_next;
        end else if (state == G_COUNT) begin
            grid[row] <= '0;
        end
    end

    always_ff @(posedge conf_clk) begin
        if (rd_pop) begin
            op_q   <= rd_op;
            mask_q <= col_mask;
            y0_q   <= rd_y0;
            y1_q   <= rd_y1;
            acc    <= '0;
        end
        if (state == G_COUNT) begin
            if (row_last) begin
                result_count <= acc + row_ones;
            end else begin
                acc <= acc + row_ones;
            end
        end
    end

endmodule

// File: hw/light_pkg.sv
package light_pkg;

    // Action carried by one instruction
    typedef enum logic [1:0] {
        OP_ON,
        OP_OFF,
        OP_TOGGLE
    } op_e;

    // One parsed decimal coordinate, saturates at 4095
    localparam int COORD_WIDTH = 12;

    // Buffer word holds the last-file marker, the op and four coordinates
    localparam int INSTR_WIDTH = 1 + 2 + 4 * COORD_WIDTH;

    // Lit-light count reported at end of file
    localparam int RESULT_WIDTH = 24;

    // End of a puzzle file
    localparam logic [7:0] ASCII_EOT = 8'h04;

endpackage

// File: hw/light_puzzle_top.sv
`timescale 1ns/1ns

module light_puzzle_top import light_pkg::*; #(
    parameter int GRID_SIZE  = 16,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                    conf_clk,
    input  logic                    rst_n,
    input  logic                    byte_valid,
    input  logic [7:0]              byte_data,
    output logic                    result_valid,
    output logic [RESULT_WIDTH-1:0] result_count,
    output logic                    parse_error,
    output logic                    overflow
);

    // Decoder to buffer
    logic                   wr_valid;
    op_e                    wr_op;
    logic [COORD_WIDTH-1:0] wr_x0;
    logic [COORD_WIDTH-1:0] wr_y0;
    logic [COORD_WIDTH-1:0] wr_x1;
    logic [COORD_WIDTH-1:0] wr_y1;
    logic                   wr_last;

    // Buffer to engine
    logic                   rd_valid;
    logic                   rd_pop;
    op_e                    rd_op;
    logic [COORD_WIDTH-1:0] rd_x0;
    logic [COORD_WIDTH-1:0] rd_y0;
    logic [COORD_WIDTH-1:0] rd_x1;
    logic [COORD_WIDTH-1:0] rd_y1;
    logic                   rd_last;

    line_decoder u_line_decoder (
        .conf_clk    (conf_clk),
        .rst_n       (rst_n),
        .byte_valid  (byte_valid),
        .byte_data   (byte_data),
        .wr_valid    (wr_valid),
        .wr_op       (wr_op),
        .wr_x0       (wr_x0),
        .wr_y0       (wr_y0),
        .wr_x1       (wr_x1),
        .wr_y1       (wr_y1),
        .wr_last     (wr_last),
        .parse_error (parse_error)
    );

    instruction_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_instruction_buffer (
        .conf_clk (conf_clk),
        .rst_n    (rst_n),
        .wr_valid (wr_valid),
        .wr_op    (wr_op),
        .wr_x0    (wr_x0),
        .wr_y0    (wr_y0),
        .wr_x1    (wr_x1),
        .wr_y1    (wr_y1),
        .wr_last  (wr_last),
        .rd_pop   (rd_pop),
        .rd_valid (rd_valid),
        .rd_op    (rd_op),
        .rd_x0    (rd_x0),
        .rd_y0    (rd_y0),
        .rd_x1    (rd_x1),
        .rd_y1    (rd_y1),
        .rd_last  (rd_last),
        .overflow (overflow)
    );

    light_grid #(
        .GRID_SIZE (GRID_SIZE)
    ) u_light_grid (
        .conf_clk     (conf_clk),
        .rst_n        (rst_n),
        .rd_valid     (rd_valid),
        .rd_op        (rd_op),
        .rd_x0        (rd_x0),
        .rd_y0        (rd_y0),
        .rd_x1        (rd_x1),
        .rd_y1        (rd_y1),
        .rd_last      (rd_last),
        .rd_pop       (rd_pop),
        .result_valid (result_valid),
        .result_count (result_count)
    );

endmodule

// File: hw/line_decoder.sv
`timescale 1ns/1ns

module line_decoder import light_pkg::*; (
    input  logic                   conf_clk,
    input  logic                   rst_n,
    input  logic                   byte_valid,
    input  logic [7:0]             byte_data,
    output logic                   wr_valid,
    output op_e                    wr_op,
    output logic [COORD_WIDTH-1:0] wr_x0,
    output logic [COORD_WIDTH-1:0] wr_y0,
    output logic [COORD_WIDTH-1:0] wr_x1,
    output logic [COORD_WIDTH-1:0] wr_y1,
    output logic                   wr_last,
    output logic                   parse_error
);

    localparam logic [7:0] ASCII_LF = 8'h0a;
    localparam logic [63:0] THROUGH = "through ";

    typedef enum logic [1:0] {
        S_KEY,
        S_NUM,
        S_THRU,
        S_SKIP
    } state_e;

    state_e                 state;
    logic [1:0]             fidx;
    logic [3:0]             tpos;
    logic [COORD_WIDTH-1:0] acc;
    logic [COORD_WIDTH-1:0] num_q [3];
    logic                   have_digit;
    logic                   line_started;
    logic                   seen_o;
    logic                   op_known;
    logic                   prev_space;
    op_e                    op_q;
    logic                   is_digit;
    logic                   is_lower;
    logic                   is_space;
    logic                   is_lf;
    logic                   is_eot;
    logic                   line_done;
    logic                   eot_hit;
    logic [7:0]             thru_char;

    // Decimal accumulate, pinned at the top of the coordinate range
    function automatic logic [COORD_WIDTH-1:0] push_digit(
        input logic [COORD_WIDTH-1:0] value,
        input logic [7:0]             ch
    );
        logic [COORD_WIDTH+3:0] wide;
        wide = value * (COORD_WIDTH + 4)'(10) + (COORD_WIDTH + 4)'(ch[3:0]);
        return (wide[COORD_WIDTH+3:COORD_WIDTH] != '0) ? '1 : wide[COORD_WIDTH-1:0];
    endfunction

    assign is_digit  = (byte_data >= "0") && (byte_data <= "9");
    assign is_lower  = (byte_data >= "a") && (byte_data <= "z");
    assign is_space  = byte_data == " ";
    assign is_lf     = byte_data == ASCII_LF;
    assign is_eot    = byte_data == ASCII_EOT;
    assign thru_char = THROUGH[8 * (7 - tpos[2:0]) +: 8];

    // Newline after the fourth number completes a line
    assign line_done = byte_valid && !is_eot && (state == S_NUM) && (fidx == 2'd3)
                       && have_digit && is_lf;
    assign eot_hit   = byte_valid && is_eot;

    always_ff @(posedge conf_clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_KEY;
            fidx         <= '0;
            tpos         <= '0;
            acc          <= '0;
            num_q        <= '{default: '0};
            have_digit   <= 1'b0;
            line_started <= 1'b0;
            seen_o       <= 1'b0;
            op_known     <= 1'b0;
            prev_space   <= 1'b0;
            op_q         <= OP_ON;
            wr_valid     <= 1'b0;
            parse_error  <= 1'b0;
        end else begin
            wr_valid <= line_done || eot_hit;
            // Keyword flags only live while the keyword is read
            if ((state != S_KEY) || eot_hit) begin
                line_started <= 1'b0;
                seen_o       <= 1'b0;
                op_known     <= 1'b0;
                prev_space   <= 1'b0;
            end
            if (eot_hit) begin
                state      <= S_KEY;
                have_digit <= 1'b0;
            end else if (byte_valid) begin
                case (state)
                    S_KEY: begin
                        if (is_lf) begin
                            // Blank lines pass silently
                            if (line_started) begin
                                parse_error <= 1'b1;
                            end
                            line_started <= 1'b0;
                            seen_o       <= 1'b0;
                            op_known     <= 1'b0;
                            prev_space   <= 1'b0;
                        end else if (is_lower || is_space) begin
                            line_started <= 1'b1;
                            prev_space   <= is_space;
                            seen_o       <= byte_data == "o";
                            // Letter after the first o picks the op
                            if (seen_o && !op_known) begin
                                op_known <= 1'b1;
                                if (byte_data == "n") begin
                                    op_q <= OP_ON;
                                end else if (byte_data == "f") begin
                                    op_q <= OP_OFF;
                                end else if (byte_data == "g") begin
                                    op_q <= OP_TOGGLE;
                                end else begin
                                    parse_error <= 1'b1;
                                    state       <= S_SKIP;
                                end
                            end
                        end else if (is_digit && op_known && prev_space) begin
                            acc        <= COORD_WIDTH'(byte_data[3:0]);
                            have_digit <= 1'b1;
                            fidx       <= 2'd0;
                            state      <= S_NUM;
                        end else begin
                            parse_error <= 1'b1;
                            state       <= S_SKIP;
                        end
                    end
                    S_NUM: begin
                        if (is_digit) begin
                            acc        <= push_digit(acc, byte_data);
                            have_digit <= 1'b1;
                        end else if (have_digit && (byte_data == ",") && !fidx[0]) begin
                            num_q[fidx] <= acc;
                            acc         <= '0;
                            have_digit  <= 1'b0;
                            fidx        <= fidx + 2'd1;
                        end else if (have_digit && is_space && (fidx == 2'd1)) begin
                            num_q[1] <= acc;
                            tpos     <= '0;
                            state    <= S_THRU;
                        end else if (line_done) begin
                            state <= S_KEY;
                        end else begin
                            parse_error <= 1'b1;
                            state       <= is_lf ? S_KEY : S_SKIP;
                        end
                    end
                    S_THRU: begin
                        if ((tpos == 4'd8) && is_digit) begin
                            acc        <= COORD_WIDTH'(byte_data[3:0]);
                            have_digit <= 1'b1;
                            fidx       <= 2'd2;
                            state      <= S_NUM;
                        end else if ((tpos != 4'd8) && (byte_data == thru_char)) begin
                            tpos <= tpos + 4'd1;
                        end else begin
                            parse_error <= 1'b1;
                            state       <= is_lf ? S_KEY : S_SKIP;
                        end
                    end
                    default: begin
                        // Discard the rest of a bad line
                        if (is_lf) begin
                            state <= S_KEY;
                        end
                    end
                endcase
            end
        end
    end

    // Corners leave ordered low to high per axis
    always_ff @(posedge conf_clk) begin
        if (line_done) begin
            wr_last <= 1'b0;
            wr_op   <= op_q;
            wr_x0   <= (num_q[0] < num_q[2]) ? num_q[0] : num_q[2];
            wr_x1   <= (num_q[0] < num_q[2]) ? num_q[2] : num_q[0];
            wr_y0   <= (num_q[1] < acc) ? num_q[1] : acc;
            wr_y1   <= (num_q[1] < acc) ? acc : num_q[1];
        end else if (eot_hit) begin
            wr_last <= 1'b1;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the light puzzle testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -Wno-fatal --top-module tb_light_puzzle \
        -Mdir obj_dir -o sim_light_puzzle -f flist.f; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_light_puzzle > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Result: fail"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

echo "Result: pass"
exit 0

// File: verif/light_puzzle_sva.sv
`timescale 1ns/1ns

module light_puzzle_sva (
    input logic conf_clk,
    input logic rst_n,
    input logic rd_pop,
    input logic result_valid,
    input logic parse_error
);

    // One pop per accepted instruction
    pop_single: assert property (
        @(posedge conf_clk) disable iff (!rst_n) rd_pop |=> !rd_pop
    ) else $error("rd_pop high on two cycles in a row");

    result_single: assert property (
        @(posedge conf_clk) disable iff (!rst_n) result_valid |=> !result_valid
    ) else $error("result_valid high on two cycles in a row");

    // Sticky until reset
    error_sticky: assert property (
        @(posedge conf_clk) disable iff (!rst_n) parse_error |=> parse_error
    ) else $error("parse_error fell without a reset");

endmodule

bind light_puzzle_top light_puzzle_sva u_light_puzzle_sva (
    .conf_clk     (conf_clk),
    .rst_n        (rst_n),
    .rd_pop       (rd_pop),
    .result_valid (result_valid),
    .parse_error  (parse_error)
);

// File: verif/tb_light_puzzle.sv
`timescale 1ns/1ns

module tb_light_puzzle import light_pkg::*; ();

    localparam int GRID_SIZE = 16;

    logic                    conf_clk;
    logic                    rst_n;
    logic                    byte_valid;
    logic [7:0]              byte_data;
    logic                    result_valid;
    logic [RESULT_WIDTH-1:0] result_count;
    logic                    parse_error;
    logic                    overflow;

    bit model_grid [GRID_SIZE][GRID_SIZE];
    int eot_sent;
    int pulses_seen;
    bit run_done;
    bit fail_seen;

    light_puzzle_top u_light_puzzle_top (
        .conf_clk     (conf_clk),
        .rst_n        (rst_n),
        .byte_valid   (byte_valid),
        .byte_data    (byte_data),
        .result_valid (result_valid),
        .result_count (result_count),
        .parse_error  (parse_error),
        .overflow     (overflow)
    );

    initial begin
        conf_clk = 1'b0;
        forever #2 conf_clk = ~conf_clk;
    end

    // Every result strobe, to compare against the EOT count at the end
    always @(negedge conf_clk) begin
        if (result_valid) begin
            pulses_seen++;
        end
    end

    function automatic string op_keyword(input op_e op);
        case (op)
            OP_ON:   return "turn on";
            OP_OFF:  return "turn off";
            default: return "toggle";
        endcase
    endfunction

    // Reference rules: order corners, clip at the grid edge, then act
    function automatic void apply_line(input op_e op, input int ax, input int ay,
                                       input int bx, input int by);
        int xl;
        int xh;
        int yl;
        int yh;
        xl = (ax < bx) ? ax : bx;
        xh = (ax < bx) ? bx : ax;
        yl = (ay < by) ? ay : by;
        yh = (ay < by) ? by : ay;
        for (int y = yl; (y <= yh) && (y < GRID_SIZE); y++) begin
            for (int x = xl; (x <= xh) && (x < GRID_SIZE); x++) begin
                case (op)
                    OP_ON:   model_grid[y][x] = 1'b1;
                    OP_OFF:  model_grid[y][x] = 1'b0;
                    default: model_grid[y][x] = !model_grid[y][x];
                endcase
            end
        end
    endfunction

    // Count and clear, as the engine leaves the grid dark
    function automatic int take_lit_count();
        int total;
        total = 0;
        for (int y = 0; y < GRID_SIZE; y++) begin
            for (int x = 0; x < GRID_SIZE; x++) begin
                total += int'(model_grid[y][x]);
                model_grid[y][x] = 1'b0;
            end
        end
        return total;
    endfunction

    task automatic fail_run(input string reason);
        fail_seen = 1'b1;
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input int expected);
        if (actual !== expected) begin
            fail_run($sformatf("mismatch at time %0t: %s is %0d, expected %0d",
                               $time, what, actual, expected));
        end
    endtask

    task automatic apply_reset();
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        repeat (2) @(negedge conf_clk);
        rst_n = 1'b1;
        void'(take_lit_count());
    endtask

    // Called on a falling edge, returns on one
    task automatic send_byte(input logic [7:0] value);
        int idle;
        idle       = $urandom_range(3, 0);
        byte_valid = 1'b1;
        byte_data  = value;
        @(negedge conf_clk);
        byte_valid = 1'b0;
        repeat (idle) @(negedge conf_clk);
    endtask

    task automatic send_text(input string text);
        for (int i = 0; i < text.len(); i++) begin
            send_byte(text[i]);
        end
        send_byte(8'h0a);
    endtask

    task automatic send_line(input op_e op, input int ax, input int ay,
                             input int bx, input int by);
        send_text($sformatf("%s %0d,%0d through %0d,%0d", op_keyword(op), ax, ay, bx, by));
        apply_line(op, ax, ay, bx, by);
    endtask

    task automatic send_random_line();
        op_e op;
        op = op_e'($urandom_range(2, 0));
        send_line(op, $urandom_range(GRID_SIZE + 3, 0), $urandom_range(GRID_SIZE + 3, 0),
                  $urandom_range(GRID_SIZE + 3, 0), $urandom_range(GRID_SIZE + 3, 0));
    endtask

    task automatic finish_file(input string name, input int lines);
        int expected;
        int waited;
        expected = take_lit_count();
        send_byte(ASCII_EOT);
        eot_sent++;
        waited = 0;
        while (!result_valid) begin
            if (waited >= 40 * GRID_SIZE * (lines + 1)) begin
                fail_run($sformatf("timeout: no result arrived for %s", name));
            end
            @(negedge conf_clk);
            waited++;
        end
        check_value(name, result_count, expected);
        @(negedge conf_clk);
    endtask

    initial begin
        int n;
        void'($urandom(80803));
        rst_n      = 1'b0;
        byte_valid = 1'b0;
        byte_data  = 8'h00;
        apply_reset();

        // One op at a time on a known background
        send_line(OP_ON, 1, 2, 10, 12);
        finish_file("on file", 1);
        send_line(OP_ON, 0, 0, 15, 15);
        send_line(OP_OFF, 12, 3, 4, 9);
        finish_file("off file", 2);
        send_line(OP_ON, 0, 0, 7, 15);
        send_line(OP_TOGGLE, 4, 0, 11, 15);
        finish_file("toggle file", 2);

        for (int f = 0; f < 10; f++) begin
            n = $urandom_range(20, 5);
            repeat (n) send_random_line();
            finish_file($sformatf("random file %0d", f), n);
        end

        // Partly and fully beyond the edge
        send_line(OP_ON, 19, 18, 10, 10);
        finish_file("clipped file", 1);
        send_line(OP_ON, 16, 16, 19, 19);
        send_line(OP_TOGGLE, 17, 0, 19, 15);
        finish_file("outside file", 2);

        // Second count must not see the first file
        send_line(OP_ON, 0, 0, 15, 15);
        finish_file("full file", 1);
        send_line(OP_TOGGLE, 0, 0, 3, 3);
        finish_file("follow-up file", 1);

        check_value("parse_error before bad lines", parse_error, 0);
        send_random_line();
        send_text("toggle 2,2 thru 9,9");
        send_random_line();
        send_text("turn on 3,# through 5,5");
        send_random_line();
        check_value("parse_error after bad lines", parse_error, 1);
        finish_file("file with bad lines", 5);
        apply_reset();
        check_value("parse_error after reset", parse_error, 0);
        n = $urandom_range(20, 5);
        repeat (n) send_random_line();
        finish_file("file after reset", n);

        repeat (4) @(negedge conf_clk);
        check_value("overflow", overflow, 0);
        check_value("result pulses", pulses_seen, eot_sent);
        run_done = 1'b1;
        $display("SIMULATION PASSED");
        $finish;
    end

    // Run stopped by a failed assertion
    final begin
        if (!run_done && !fail_seen) begin
            $display("SIMULATION FAILED");
        end
    end

endmodule
